/* source/skdec_params.svh */
`ifndef SKDEC_PARAMS_SVH
`define SKDEC_PARAMS_SVH

// Polynomial counts and size, kept small for simulation
`define SKDEC_L 2
`define SKDEC_K 3
`define SKDEC_N 16

// Modulus and code offsets
`define SKDEC_Q 8380417
`define SKDEC_ETA 2
`define SKDEC_T0_OFS 4096

`define SKDEC_ADDR_W 10
`define SKDEC_AXI_ADDR_W 13

// Register offsets below the RAM window
`define SKDEC_REG_CTRL 4'h0
`define SKDEC_REG_STATUS 4'h4
`define SKDEC_REG_SRC 4'h8
`define SKDEC_REG_DEST 4'hC

`endif

/* source/skdec_pkg.sv */
`include "skdec_params.svh"

package skdec_pkg;

    typedef logic [`SKDEC_ADDR_W-1:0] ram_addr_t;
    typedef logic [31:0] ram_word_t;
    typedef logic [23:0] coeff_t;

    // One access to the shared word RAM
    typedef struct packed {
        logic      req;
        logic      we;
        ram_addr_t addr;
        ram_word_t wdata;
    } ram_req_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_S1,
        RD_S2,
        RD_T0
    } skdec_rd_state_e;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_S1,
        WR_S2,
        WR_T0
    } skdec_wr_state_e;

    // STATUS register layout, error in bit 0
    typedef struct packed {
        logic busy;
        logic done;
        logic s1_done;
        logic s2_done;
        logic t0_done;
        logic error;
    } skdec_status_t;

endpackage

/* source/skdec_ram.sv */
`timescale 1ns/1ps
`include "skdec_params.svh"

module skdec_ram (
    input  logic                 clk,
    input  skdec_pkg::ram_req_t  req,
    output skdec_pkg::ram_word_t rdata
);
    import skdec_pkg::*;

    ram_word_t mem [2**`SKDEC_ADDR_W];

    // Registered read, data is valid the cycle after the request
    always_ff @(posedge clk) begin
        if (req.req) begin
            if (req.we)
                mem[req.addr] <= req.wdata;
            else
                rdata <= mem[req.addr];
        end
    end

endmodule

/* source/ram_arbiter.sv */
`timescale 1ns/1ps

module ram_arbiter (
    input  logic                 clk,
    input  logic                 reset_n,
    input  skdec_pkg::ram_req_t  wr_req,
    input  skdec_pkg::ram_req_t  rd_req,
    input  skdec_pkg::ram_req_t  host_req,
    output logic                 wr_gnt,
    output logic                 rd_gnt,
    output logic                 host_gnt,
    output logic                 rd_valid,
    output logic                 host_valid,
    output skdec_pkg::ram_word_t rdata,
    output skdec_pkg::ram_req_t  ram_req,
    input  skdec_pkg::ram_word_t ram_rdata
);

    // Owner of the read that is on its way back
    logic rd_tag, host_tag;

    // Fixed priority: coefficient write, key read, host
    assign wr_gnt   = wr_req.req;
    assign rd_gnt   = rd_req.req & ~wr_req.req;
    assign host_gnt = host_req.req & ~wr_req.req & ~rd_req.req;

    always_comb begin
        if (wr_gnt)
            ram_req = wr_req;
        else if (rd_gnt)
            ram_req = rd_req;
        else if (host_gnt)
            ram_req = host_req;
        else
            ram_req = '0;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_tag   <= 1'b0;
            host_tag <= 1'b0;
        end else begin
            rd_tag   <= rd_gnt & ~rd_req.we;
            host_tag <= host_gnt & ~host_req.we;
        end
    end

    assign rd_valid   = rd_tag;
    assign host_valid = host_tag;
    assign rdata      = ram_rdata;

endmodule

/* source/skdec_s_unpack.sv */
`timescale 1ns/1ps
`include "skdec_params.svh"

module skdec_s_unpack (
    input  logic                 clk,
    input  logic                 reset_n,
    input  skdec_pkg::ram_word_t word,
    input  logic                 word_valid,
    output logic                 word_ready,
    output skdec_pkg::coeff_t    coeff,
    output logic                 coeff_valid,
    input  logic                 coeff_ready,
    output logic                 range_error
);
    import skdec_pkg::*;

    ram_word_t  word_q;
    logic [2:0] idx;
    logic [2:0] code;
    logic       full, take;

    // Eight 3-bit codes, c0 in the low bits
    assign code        = word_q[3*idx +: 3];
    assign range_error = full & (code > 3'd4);
    assign coeff_valid = full & ~range_error;
    assign take        = coeff_valid & coeff_ready;
    // Next word may land while the last code leaves
    assign word_ready  = ~full | (take & (idx == 3'd7));

    // ETA minus code, wrapped below Q
    always_comb begin
        if (code > 3'(`SKDEC_ETA))
            coeff = coeff_t'(`SKDEC_Q + `SKDEC_ETA) - coeff_t'(code);
        else
            coeff = coeff_t'(`SKDEC_ETA) - coeff_t'(code);
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            full <= 1'b0;
            idx  <= '0;
        end else if (word_valid && word_ready) begin
            full <= 1'b1;
            idx  <= '0;
        end else if (range_error) begin
            // Bad code, drop the rest of the word
            full <= 1'b0;
        end else if (take) begin
            full <= (idx != 3'd7);
            idx  <= idx + 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (word_valid && word_ready)
            word_q <= word;
    end

endmodule

/* source/skdec_t0_unpack.sv */
`timescale 1ns/1ps
`include "skdec_params.svh"

module skdec_t0_unpack (
    input  logic                 clk,
    input  logic                 reset_n,
    input  skdec_pkg::ram_word_t word,
    input  logic                 word_valid,
    output logic                 word_ready,
    output skdec_pkg::coeff_t    coeff,
    output logic                 coeff_valid,
    input  logic                 coeff_ready
);
    import skdec_pkg::*;

    ram_word_t   word_q;
    logic [12:0] code;
    logic        full, upper, take;

    // Low code first, then bits 25..13
    assign code        = upper ? word_q[25:13] : word_q[12:0];
    assign coeff_valid = full;
    assign take        = full & coeff_ready;
    // Next word may land while the second code leaves
    assign word_ready  = ~full | (take & upper);

    // T0_OFS minus code, wrapped below Q
    always_comb begin
        if (code > 13'(`SKDEC_T0_OFS))
            coeff = coeff_t'(`SKDEC_Q + `SKDEC_T0_OFS) - coeff_t'(code);
        else
            coeff = coeff_t'(`SKDEC_T0_OFS) - coeff_t'(code);
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            full  <= 1'b0;
            upper <= 1'b0;
        end else if (word_valid && word_ready) begin
            full  <= 1'b1;
            upper <= 1'b0;
        end else if (take) begin
            full  <= ~upper;
            upper <= ~upper;
        end
    end

    always_ff @(posedge clk) begin
        if (word_valid && word_ready)
            word_q <= word;
    end

endmodule

/* source/skdec_ctrl.sv */
`timescale 1ns/1ps
`include "skdec_params.svh"

module skdec_ctrl (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     start,
    input  logic                     clear,
    input  skdec_pkg::ram_addr_t     src_base,
    input  skdec_pkg::ram_addr_t     dest_base,
    output skdec_pkg::ram_req_t      rd_req,
    input  logic                     rd_gnt,
    input  logic                     rd_valid,
    input  skdec_pkg::ram_word_t     rdata,
    output logic                     s_word_valid,
    input  logic                     s_word_ready,
    output logic                     t0_word_valid,
    input  logic                     t0_word_ready,
    output skdec_pkg::ram_word_t     word,
    input  skdec_pkg::coeff_t        s_coeff,
    input  skdec_pkg::coeff_t        t0_coeff,
    input  logic                     s_coeff_valid,
    input  logic                     t0_coeff_valid,
    output logic                     s_coeff_ready,
    output logic                     t0_coeff_ready,
    input  logic                     range_error,
    output skdec_pkg::ram_req_t      wr_req,
    input  logic                     wr_gnt,
    output skdec_pkg::skdec_status_t status
);
    import skdec_pkg::*;

    // Last key word and last coefficient index of each phase
    localparam logic [4:0] S1_RD_LAST = 5'(`SKDEC_L * `SKDEC_N / 8 - 1);
    localparam logic [4:0] S2_RD_LAST = 5'(`SKDEC_K * `SKDEC_N / 8 - 1);
    localparam logic [4:0] T0_RD_LAST = 5'(`SKDEC_K * `SKDEC_N / 2 - 1);
    localparam logic [5:0] S1_WR_LAST = 6'(`SKDEC_L * `SKDEC_N - 1);
    localparam logic [5:0] KN_WR_LAST = 6'(`SKDEC_K * `SKDEC_N - 1);

    skdec_rd_state_e rd_state, rd_next;
    skdec_wr_state_e wr_state, wr_next;
    logic [4:0]      rd_cnt, rd_last;
    logic [5:0]      wr_cnt, wr_last;
    ram_addr_t       rd_addr, wr_addr;
    ram_word_t       word_q;
    logic            rd_req_on, rd_busy, word_pend, word_t0;
    logic            go, abort, s_phase, launch, handoff;
    logic            done_q, s1_done_q, s2_done_q, t0_done_q, error_q;

    assign go      = start & (rd_state == RD_IDLE) & (wr_state == WR_IDLE);
    assign s_phase = (wr_state == WR_S1) | (wr_state == WR_S2);
    // A bad code only counts while s coefficients are being written
    assign abort   = clear | (range_error & s_phase);

    // ----------------------------------------
    // Key reads
    // ----------------------------------------
    always_comb begin
        rd_last = T0_RD_LAST;
        rd_next = RD_IDLE;
        case (rd_state)
            RD_S1: begin
                rd_last = S1_RD_LAST;
                rd_next = RD_S2;
            end
            RD_S2: begin
                rd_last = S2_RD_LAST;
                rd_next = RD_T0;
            end
            default: ;
        endcase
    end

    // One read in flight, issued when the target unpacker is empty or draining
    assign launch = (rd_state != RD_IDLE) & ~rd_busy & ~abort &
                    ((rd_state == RD_T0) ? t0_word_ready : s_word_ready);
    assign handoff = word_pend & (word_t0 ? t0_word_ready : s_word_ready);

    assign rd_req = '{req: rd_req_on | launch, we: 1'b0, addr: rd_addr, wdata: '0};
    assign s_word_valid  = word_pend & ~word_t0;
    assign t0_word_valid = word_pend & word_t0;
    assign word          = word_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_state  <= RD_IDLE;
            rd_cnt    <= '0;
            rd_addr   <= '0;
            rd_req_on <= 1'b0;
            rd_busy   <= 1'b0;
            word_pend <= 1'b0;
            word_t0   <= 1'b0;
        end else if (abort) begin
            rd_state  <= RD_IDLE;
            rd_req_on <= 1'b0;
            rd_busy   <= 1'b0;
            word_pend <= 1'b0;
        end else begin
            rd_req_on <= (rd_req_on | launch) & ~rd_gnt;
            if (go) begin
                rd_state <= RD_S1;
                rd_cnt   <= '0;
                rd_addr  <= src_base;
            end
            if (rd_gnt) begin
                rd_addr <= rd_addr + 1'b1;
                word_t0 <= (rd_state == RD_T0);
                if (rd_cnt == rd_last) begin
                    rd_cnt   <= '0;
                    rd_state <= rd_next;
                end else begin
                    rd_cnt <= rd_cnt + 1'b1;
                end
            end
            if (launch)
                rd_busy <= 1'b1;
            else if (handoff)
                rd_busy <= 1'b0;
            // Data of a read issued before an abort is ignored
            if (rd_valid && rd_busy)
                word_pend <= 1'b1;
            else if (handoff)
                word_pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_valid)
            word_q <= rdata;
    end

    // ----------------------------------------
    // Coefficient writes
    // ----------------------------------------
    always_comb begin
        wr_last = KN_WR_LAST;
        wr_next = WR_IDLE;
        case (wr_state)
            WR_S1: begin
                wr_last = S1_WR_LAST;
                wr_next = WR_S2;
            end
            WR_S2: wr_next = WR_T0;
            default: ;
        endcase
    end

    assign wr_req = '{
        req:   s_phase ? s_coeff_valid : ((wr_state == WR_T0) & t0_coeff_valid),
        we:    1'b1,
        addr:  wr_addr,
        wdata: ram_word_t'(s_phase ? s_coeff : t0_coeff)
    };

    // While idle, leftovers from an aborted decode are flushed
    assign s_coeff_ready  = s_phase ? wr_gnt : (wr_state == WR_IDLE);
    assign t0_coeff_ready = (wr_state == WR_T0) ? wr_gnt : (wr_state == WR_IDLE);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_state <= WR_IDLE;
            wr_cnt   <= '0;
            wr_addr  <= '0;
        end else if (abort) begin
            wr_state <= WR_IDLE;
        end else if (go) begin
            wr_state <= WR_S1;
            wr_cnt   <= '0;
            wr_addr  <= dest_base;
        end else if (wr_gnt) begin
            wr_addr <= wr_addr + 1'b1;
            if (wr_cnt == wr_last) begin
                wr_cnt   <= '0;
                wr_state <= wr_next;
            end else begin
                wr_cnt <= wr_cnt + 1'b1;
            end
        end
    end

    // Phase flags and sticky error
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            {done_q, s1_done_q, s2_done_q, t0_done_q, error_q} <= '0;
        end else if (clear || go) begin
            {done_q, s1_done_q, s2_done_q, t0_done_q, error_q} <= '0;
        end else begin
            if (abort)
                error_q <= 1'b1;
            if (wr_gnt && wr_cnt == wr_last) begin
                case (wr_state)
                    WR_S1: s1_done_q <= 1'b1;
                    WR_S2: s2_done_q <= 1'b1;
                    WR_T0: begin
                        t0_done_q <= 1'b1;
                        done_q    <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    assign status = '{
        busy:    (wr_state != WR_IDLE),
        done:    done_q,
        s1_done: s1_done_q,
        s2_done: s2_done_q,
        t0_done: t0_done_q,
        error:   error_q
    };

endmodule

/* source/skdec_axil_regs.sv */
`timescale 1ns/1ps
`include "skdec_params.svh"

module skdec_axil_regs (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic [`SKDEC_AXI_ADDR_W-1:0] awaddr,
    input  logic                         awvalid,
    output logic                         awready,
    input  logic [31:0]                  wdata,
    input  logic [3:0]                   wstrb,
    input  logic                         wvalid,
    output logic                         wready,
    output logic [1:0]                   bresp,
    output logic                         bvalid,
    input  logic                         bready,
    input  logic [`SKDEC_AXI_ADDR_W-1:0] araddr,
    input  logic                         arvalid,
    output logic                         arready,
    output logic [31:0]                  rdata,
    output logic [1:0]                   rresp,
    output logic                         rvalid,
    input  logic                         rready,
    output logic                         start,
    output logic                         clear,
    output skdec_pkg::ram_addr_t         src_base,
    output skdec_pkg::ram_addr_t         dest_base,
    input  skdec_pkg::skdec_status_t     status,
    output skdec_pkg::ram_req_t          host_req,
    input  logic                         host_gnt,
    input  logic                         host_valid,
    input  skdec_pkg::ram_word_t         host_rdata
);

    logic        host_rd_wait, host_busy, aw_ok, ar_ok, wr_en;
    logic [31:0] reg_rdata;

    // Window accesses go one at a time, writes take precedence
    assign host_busy = host_req.req | host_rd_wait;
    assign aw_ok     = awvalid & wvalid & ~bvalid & ~host_busy;
    assign ar_ok     = arvalid & ~rvalid & ~host_busy & ~aw_ok;
    assign awready   = aw_ok;
    assign wready    = aw_ok;
    assign arready   = ar_ok;
    assign wr_en     = |wstrb;
    assign bresp     = 2'b00;
    assign rresp     = 2'b00;

    always_comb begin
        case (araddr[3:0])
            `SKDEC_REG_STATUS: reg_rdata = 32'(status);
            `SKDEC_REG_SRC:    reg_rdata = 32'(src_base);
            `SKDEC_REG_DEST:   reg_rdata = 32'(dest_base);
            default:           reg_rdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            host_req     <= '0;
            host_rd_wait <= 1'b0;
            bvalid       <= 1'b0;
            rvalid       <= 1'b0;
            rdata        <= '0;
            start        <= 1'b0;
            clear        <= 1'b0;
            src_base     <= '0;
            dest_base    <= '0;
        end else begin
            start <= 1'b0;
            clear <= 1'b0;
            if (bvalid && bready)
                bvalid <= 1'b0;
            if (rvalid && rready)
                rvalid <= 1'b0;

            // ----------------------------------------
            // Write channel
            // ----------------------------------------
            if (aw_ok) begin
                if (awaddr[12] && wr_en) begin
                    host_req <= '{req: 1'b1, we: 1'b1, addr: awaddr[11:2], wdata: wdata};
                end else begin
                    bvalid <= 1'b1;
                    if (wr_en && !awaddr[12]) begin
                        case (awaddr[3:0])
                            `SKDEC_REG_CTRL: begin
                                start <= wdata[0];
                                clear <= wdata[1];
                            end
                            `SKDEC_REG_SRC:  src_base  <= wdata[`SKDEC_ADDR_W-1:0];
                            `SKDEC_REG_DEST: dest_base <= wdata[`SKDEC_ADDR_W-1:0];
                            default: ;
                        endcase
                    end
                end
            end

            // ----------------------------------------
            // Read channel
            // ----------------------------------------
            if (ar_ok) begin
                if (araddr[12]) begin
                    host_req <= '{req: 1'b1, we: 1'b0, addr: araddr[11:2], wdata: '0};
                end else begin
                    rvalid <= 1'b1;
                    rdata  <= reg_rdata;
                end
            end

            // Window response waits for the grant and any read data
            if (host_gnt) begin
                host_req.req <= 1'b0;
                if (host_req.we)
                    bvalid <= 1'b1;
                else
                    host_rd_wait <= 1'b1;
            end
            if (host_valid) begin
                host_rd_wait <= 1'b0;
                rvalid       <= 1'b1;
                rdata        <= host_rdata;
            end
        end
    end

endmodule

/* source/skdec_top.sv */
`timescale 1ns/1ps
`include "skdec_params.svh"

module skdec_top (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic [`SKDEC_AXI_ADDR_W-1:0] awaddr,
    input  logic                         awvalid,
    output logic                         awready,
    input  logic [31:0]                  wdata,
    input  logic [3:0]                   wstrb,
    input  logic                         wvalid,
    output logic                         wready,
    output logic [1:0]                   bresp,
    output logic                         bvalid,
    input  logic                         bready,
    input  logic [`SKDEC_AXI_ADDR_W-1:0] araddr,
    input  logic                         arvalid,
    output logic                         arready,
    output logic [31:0]                  rdata,
    output logic [1:0]                   rresp,
    output logic                         rvalid,
    input  logic                         rready
);
    import skdec_pkg::*;

    logic          start, clear, range_error;
    ram_addr_t     src_base, dest_base;
    skdec_status_t status;
    ram_req_t      host_req, rd_req, wr_req, ram_req;
    logic          host_gnt, host_valid, rd_gnt, rd_valid, wr_gnt;
    ram_word_t     arb_rdata, ram_rdata, word;
    logic          s_word_valid, s_word_ready, t0_word_valid, t0_word_ready;
    coeff_t        s_coeff, t0_coeff;
    logic          s_coeff_valid, s_coeff_ready, t0_coeff_valid, t0_coeff_ready;

    skdec_axil_regs u_regs (
        .clk, .reset_n,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .start, .clear, .src_base, .dest_base, .status,
        .host_req, .host_gnt, .host_valid,
        .host_rdata (arb_rdata)
    );

    skdec_ctrl u_ctrl (
        .clk, .reset_n, .start, .clear, .src_base, .dest_base,
        .rd_req, .rd_gnt, .rd_valid,
        .rdata (arb_rdata),
        .s_word_valid, .s_word_ready, .t0_word_valid, .t0_word_ready, .word,
        .s_coeff, .t0_coeff, .s_coeff_valid, .t0_coeff_valid,
        .s_coeff_ready, .t0_coeff_ready, .range_error,
        .wr_req, .wr_gnt, .status
    );

    skdec_s_unpack u_s_unpack (
        .clk, .reset_n, .word,
        .word_valid  (s_word_valid),
        .word_ready  (s_word_ready),
        .coeff       (s_coeff),
        .coeff_valid (s_coeff_valid),
        .coeff_ready (s_coeff_ready),
        .range_error
    );

    skdec_t0_unpack u_t0_unpack (
        .clk, .reset_n, .word,
        .word_valid  (t0_word_valid),
        .word_ready  (t0_word_ready),
        .coeff       (t0_coeff),
        .coeff_valid (t0_coeff_valid),
        .coeff_ready (t0_coeff_ready)
    );

    ram_arbiter u_arbiter (
        .clk, .reset_n, .wr_req, .rd_req, .host_req,
        .wr_gnt, .rd_gnt, .host_gnt, .rd_valid, .host_valid,
        .rdata (arb_rdata),
        .ram_req, .ram_rdata
    );

    skdec_ram u_ram (
        .clk,
        .req   (ram_req),
        .rdata (ram_rdata)
    );

endmodule

/* verif/skdec_asserts.sv */
`timescale 1ns/1ps

module skdec_asserts (
    input logic       clk,
    input logic       reset_n,
    input logic [2:0] req,
    input logic [2:0] gnt,
    input logic       busy,
    input logic       done
);

    int unsigned fail_count = 0;

    // Single-port RAM, so one owner per cycle
    a_one_grant: assert property (@(posedge clk) disable iff (!reset_n) $onehot0(gnt))
        else begin
            $error("more than one RAM grant in the same cycle");
            fail_count++;
        end

    // A request that stays up is served within a bounded time
    for (genvar i = 0; i < 3; i++) begin : g_live
        a_granted: assert property (@(posedge clk) disable iff (!reset_n)
                req[i] |-> ##[0:64] (gnt[i] || !req[i]))
            else begin
                $error("RAM request %0d held without a grant", i);
                fail_count++;
            end
    end

    a_busy_done: assert property (@(posedge clk) disable iff (!reset_n) !(busy && done))
        else begin
            $error("busy and done high together");
            fail_count++;
        end

endmodule

bind ram_arbiter skdec_asserts u_arb_asserts (
    .clk,
    .reset_n,
    .req  ({wr_req.req, rd_req.req, host_req.req}),
    .gnt  ({wr_gnt, rd_gnt, host_gnt}),
    .busy (1'b0),
    .done (1'b0)
);

bind skdec_ctrl skdec_asserts u_ctrl_asserts (
    .clk,
    .reset_n,
    .req  ({wr_req.req, rd_req.req, 1'b0}),
    .gnt  ({wr_gnt, rd_gnt, 1'b0}),
    .busy (status.busy),
    .done (status.done)
);

/* verif/skdec_tb.sv */
`timescale 1ns/1ps
`include "skdec_params.svh"

module skdec_tb;
    import skdec_pkg::*;

    localparam int S_WORDS   = (`SKDEC_L + `SKDEC_K) * `SKDEC_N / 8;
    localparam int S1_WORDS  = `SKDEC_L * `SKDEC_N / 8;
    localparam int KEY_WORDS = S_WORDS + `SKDEC_K * `SKDEC_N / 2;
    localparam int NUM_COEFF = (`SKDEC_L + 2 * `SKDEC_K) * `SKDEC_N;
    localparam int NUM_TESTS = 4;
    // Key load, decode with host reads, coefficient readback
    localparam int CYCLES_PER_TEST = KEY_WORDS * 4 + NUM_COEFF * 6 + 400;
    localparam int CYCLE_LIMIT     = NUM_TESTS * CYCLES_PER_TEST + 200;

    typedef struct packed {
        ram_addr_t  src;
        ram_addr_t  dest;
        logic       inject;
        logic [5:0] err_word;
        logic [2:0] err_slot;
    } test_entry_t;

    logic                         clk;
    logic                         reset_n;
    logic [`SKDEC_AXI_ADDR_W-1:0] awaddr, araddr;
    logic                         awvalid, wvalid, bready, arvalid, rready;
    logic                         awready, wready, bvalid, arready, rvalid;
    logic [31:0]                  wdata, rdata;
    logic [3:0]                   wstrb;
    logic [1:0]                   bresp, rresp;

    test_entry_t tests [NUM_TESTS];
    ram_word_t   key_words [KEY_WORDS];
    coeff_t      expected [NUM_COEFF];
    int          cycle_count = 0;
    logic [31:0] rd_word;

    skdec_top uut (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("TEST FAIL");
            $fatal(1, "simulation stopped on timeout");
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] exp_value,
                               input string what);
        if (actual !== exp_value) begin
            $display("CHECK FAILED at %0t: %s, got %h, expected %h",
                     $time, what, actual, exp_value);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // ----------------------------------------
    // AXI4-Lite host
    // ----------------------------------------
    task automatic axi_write(input logic [12:0] addr, input logic [31:0] data);
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        #1;
        while (!awready) begin
            @(negedge clk);
            #1;
        end
        // AW and W are taken in the same cycle
        check_value(32'(wready), 32'h1, "wready together with awready");
        @(posedge clk);
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid)
            @(negedge clk);
        check_value(32'(bresp), 32'h0, "write response");
    endtask

    task automatic axi_read(input logic [12:0] addr, output logic [31:0] data);
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        #1;
        while (!arready) begin
            @(negedge clk);
            #1;
        end
        @(posedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid)
            @(negedge clk);
        check_value(32'(rresp), 32'h0, "read response");
        data = rdata;
    endtask

    function automatic logic [12:0] win_addr(input int word_addr);
        return 13'h1000 | 13'((word_addr % 1024) << 2);
    endfunction

    // ----------------------------------------
    // Reference model from the packing rule
    // ----------------------------------------
    function automatic coeff_t s_model(input logic [2:0] x);
        int v;
        v = `SKDEC_ETA - int'(x);
        if (v < 0)
            v = v + `SKDEC_Q;
        return coeff_t'(v);
    endfunction

    function automatic coeff_t t0_model(input logic [12:0] x);
        int v;
        v = `SKDEC_T0_OFS - int'(x);
        if (v < 0)
            v = v + `SKDEC_Q;
        return coeff_t'(v);
    endfunction

    function automatic void build_model();
        int k;
        k = 0;
        for (int i = 0; i < S_WORDS; i++) begin
            for (int j = 0; j < 8; j++) begin
                expected[k] = s_model(key_words[i][3*j +: 3]);
                k++;
            end
        end
        for (int i = S_WORDS; i < KEY_WORDS; i++) begin
            expected[k]     = t0_model(key_words[i][12:0]);
            expected[k + 1] = t0_model(key_words[i][25:13]);
            k = k + 2;
        end
    endfunction

    // Valid s codes only, apart from an injected bad slot
    task automatic make_key(input test_entry_t t);
        ram_word_t  w;
        logic [2:0] code;
        for (int i = 0; i < KEY_WORDS; i++) begin
            if (i < S_WORDS) begin
                w = $urandom & 32'hFF00_0000;
                for (int j = 0; j < 8; j++) begin
                    code = 3'($urandom_range(4, 0));
                    if (t.inject && i == t.err_word && j == t.err_slot)
                        code = 3'($urandom_range(7, 5));
                    w[3*j +: 3] = code;
                end
            end else begin
                w = $urandom;
            end
            key_words[i] = w;
        end
    endtask

    task automatic run_test(input int n);
        test_entry_t t;
        logic [31:0] st;
        logic [31:0] rd;
        logic [31:0] exp_status;
        int          n_check;
        t = tests[n];
        make_key(t);
        build_model();
        for (int i = 0; i < KEY_WORDS; i++)
            axi_write(win_addr(t.src + i), key_words[i]);
        axi_write(13'(`SKDEC_REG_SRC), 32'(t.src));
        axi_write(13'(`SKDEC_REG_DEST), 32'(t.dest));
        axi_write(13'(`SKDEC_REG_CTRL), 32'h1);

        // Busy only, old phase and error bits gone
        axi_read(13'(`SKDEC_REG_STATUS), st);
        check_value(st, 32'h20, $sformatf("test %0d STATUS after start", n));

        // Host reads compete with the running decode
        for (int i = 0; i < 4; i++) begin
            axi_read(win_addr(t.src + i * 9), rd);
            check_value(rd, key_words[i * 9], $sformatf("test %0d key word %0d", n, i * 9));
        end

        st = '0;
        while (!st[4] && !st[0])
            axi_read(13'(`SKDEC_REG_STATUS), st);

        if (t.inject) begin
            n_check    = t.err_word * 8 + t.err_slot;
            exp_status = (t.err_word >= S1_WORDS) ? 32'h09 : 32'h01;
        end else begin
            n_check    = NUM_COEFF;
            exp_status = 32'h1E;
        end
        check_value(st, exp_status, $sformatf("test %0d final STATUS", n));

        for (int i = 0; i < n_check; i++) begin
            axi_read(win_addr(t.dest + i), rd);
            check_value(rd, 32'(expected[i]), $sformatf("test %0d coefficient %0d", n, i));
        end
    endtask

    initial begin
        clk     = 1'b0;
        reset_n = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = 4'hF;
        wvalid  = 1'b0;
        bready  = 1'b1;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b1;
        void'($urandom(13058));

        tests[0] = '{src: 10'd0,   dest: 10'd64,  inject: 1'b0, err_word: 6'd0, err_slot: 3'd0};
        tests[1] = '{src: 10'd512, dest: 10'd700, inject: 1'b0, err_word: 6'd0, err_slot: 3'd0};
        tests[2] = '{src: 10'd200, dest: 10'd320, inject: 1'b1, err_word: 6'd6, err_slot: 3'd3};
        tests[3] = '{src: 10'd960, dest: 10'd832, inject: 1'b0, err_word: 6'd0, err_slot: 3'd0};

        repeat (8) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        // Register access after reset
        axi_read(13'(`SKDEC_REG_STATUS), rd_word);
        check_value(rd_word, 32'h0, "STATUS after reset");
        axi_write(13'(`SKDEC_REG_SRC), 32'h155);
        axi_write(13'(`SKDEC_REG_DEST), 32'h2AA);
        axi_read(13'(`SKDEC_REG_SRC), rd_word);
        check_value(rd_word, 32'h155, "SRC readback");
        axi_read(13'(`SKDEC_REG_DEST), rd_word);
        check_value(rd_word, 32'h2AA, "DEST readback");

        for (int n = 0; n < NUM_TESTS; n++)
            run_test(n);

        repeat (4) @(posedge clk);
        if (uut.u_arbiter.u_arb_asserts.fail_count == 0 &&
            uut.u_ctrl.u_ctrl_asserts.fail_count == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("Assertion failures were reported during the run");
            $display("TEST FAIL");
            $fatal(1, "assertion failures");
        end
    end

endmodule

/* verilog.f */
+incdir+source
source/skdec_pkg.sv
source/skdec_ram.sv
source/ram_arbiter.sv
source/skdec_s_unpack.sv
source/skdec_t0_unpack.sv
source/skdec_ctrl.sv
source/skdec_axil_regs.sv
source/skdec_top.sv
verif/skdec_asserts.sv
verif/skdec_tb.sv

/* Bender.yml */
package:
  name: skdec

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/skdec_pkg.sv
      - source/skdec_ram.sv
      - source/ram_arbiter.sv
      - source/skdec_s_unpack.sv
      - source/skdec_t0_unpack.sv
      - source/skdec_ctrl.sv
      - source/skdec_axil_regs.sv
      - source/skdec_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/skdec_asserts.sv
      - verif/skdec_tb.sv
